// ==== hdl/tcb_dev_select.sv ====
// TCB device select
// steers each request to the SRAM or the register block by address and
// merges their responses through a delay line of the select decision

`timescale 1ns/1ns

module tcb_dev_select (
  input  logic              man,
  input  logic              reset,
  // host side
  input  logic              host_vld,
  input  tcb_pkg::tcb_req_t host_req,
  output logic              host_rdy,
  // sram side
  output logic              sram_vld,
  output tcb_pkg::tcb_req_t sram_req,
  input  logic              sram_rdy,
  input  tcb_pkg::tcb_rsp_t sram_rsp,
  // register block side
  output logic              regs_vld,
  output tcb_pkg::tcb_req_t regs_req,
  input  logic              regs_rdy,
  input  tcb_pkg::tcb_rsp_t regs_rsp,
  // merged response and its read byte enables
  output tcb_pkg::tcb_rsp_t merged_rsp,
  output tcb_pkg::ben_t     merged_rbe
);

  ////////////////////////////////////////////////////////////
  // request routing
  ////////////////////////////////////////////////////////////

  // one stage of the response delay line
  typedef struct packed {
    logic          sel;
    tcb_pkg::ben_t rbe;
  } dly_t;

  logic                         sel;
  dly_t                         dly_in;
  dly_t [tcb_pkg::TCB_DLY-1:0]  dly_line;
  dly_t                         dly_out;

  // 0 sram, 1 registers
  assign sel = host_req.adr[tcb_pkg::SEL_BIT];

  assign sram_vld = host_vld && !sel;
  assign regs_vld = host_vld &&  sel;

  // both subordinates see the full request, only vld is steered
  assign sram_req = host_req;
  assign regs_req = host_req;

  assign host_rdy = sel ? regs_rdy : sram_rdy;

  ////////////////////////////////////////////////////////////
  // response delay line
  ////////////////////////////////////////////////////////////

  // rbe only for a read handshake, writes and idle cycles push zero
  assign dly_in.sel = sel;
  assign dly_in.rbe = (host_vld && host_rdy && !host_req.wen) ? host_req.ben : '0;

  always_ff @(posedge man) begin
    if (reset) begin
      dly_line <= '0;
    end else begin
      dly_line[0] <= dly_in;
      for (int unsigned i = 1; i < tcb_pkg::TCB_DLY; i++) begin
        dly_line[i] <= dly_line[i-1];
      end
    end
  end

  assign dly_out = dly_line[tcb_pkg::TCB_DLY-1];

  ////////////////////////////////////////////////////////////
  // response merge
  ////////////////////////////////////////////////////////////

  // back to back transfers to different devices each get their own stage
  assign merged_rsp = dly_out.sel ? regs_rsp : sram_rsp;
  assign merged_rbe = dly_out.rbe;

endmodule

// ==== hdl/tcb_pkg.sv ====
// TCB shared definitions
// bus widths, request/response structs, address map and timing constants

package tcb_pkg;

  ////////////////////////////////////////////////////////////
  // bus widths
  ////////////////////////////////////////////////////////////

  localparam int unsigned DAT_W  = 32;
  localparam int unsigned ADR_W  = 16;
  localparam int unsigned BYTE_W = 8;
  localparam int unsigned BEN_W  = DAT_W / BYTE_W;

  typedef logic [DAT_W-1:0] data_t;
  typedef logic [ADR_W-1:0] adr_t;
  typedef logic [BEN_W-1:0] ben_t;
  // bit 0 flags an error
  typedef logic [0:0]       sts_t;

  // request fields, held stable by the manager while vld && !rdy
  typedef struct packed {
    logic  wen;
    adr_t  adr;
    ben_t  ben;
    data_t wdt;
  } tcb_req_t;

  // response fields, valid TCB_DLY cycles after a subordinate handshake
  typedef struct packed {
    data_t rdt;
    sts_t  sts;
  } tcb_rsp_t;

  ////////////////////////////////////////////////////////////
  // timing and address map
  ////////////////////////////////////////////////////////////

  // subordinate read delay
  localparam int unsigned TCB_DLY = 1;

  // 0 selects the SRAM, 1 the register block
  localparam int unsigned SEL_BIT = 15;

  // word offset inside the register window (bits SEL_BIT-1 down to 2)
  typedef logic [SEL_BIT-3:0] reg_off_t;

  localparam reg_off_t REG_SCRATCH = reg_off_t'(0);
  localparam reg_off_t REG_CONTROL = reg_off_t'(1);
  localparam reg_off_t REG_WCOUNT  = reg_off_t'(2);
  localparam reg_off_t REG_ID      = reg_off_t'(3);

  localparam data_t REG_ID_VALUE = 32'h7cb5_0102;

  // replace the enabled bytes of old_dat with those of new_dat
  function automatic data_t ben_merge(data_t old_dat, data_t new_dat, ben_t ben);
    data_t res;
    res = old_dat;
    for (int unsigned b = 0; b < BEN_W; b++) begin
      if (ben[b]) begin
        res[b*BYTE_W +: BYTE_W] = new_dat[b*BYTE_W +: BYTE_W];
      end
    end
    return res;
  endfunction

endpackage

// ==== hdl/tcb_register_response.sv ====
// TCB response register slice
// request and handshake pass through, response data is held per granule
// and only updated for enabled read bytes, status is registered every cycle

`timescale 1ns/1ns

module tcb_register_response #(
  // hold granularity in bytes, 1 or 2
  parameter int unsigned GRN = 1
)(
  input  logic              man,
  input  logic              reset,
  // subordinate port, toward the manager
  input  logic              sub_vld,
  input  tcb_pkg::tcb_req_t sub_req,
  output logic              sub_rdy,
  output tcb_pkg::tcb_rsp_t sub_rsp,
  // manager port, toward the devices
  output logic              man_vld,
  output tcb_pkg::tcb_req_t man_req,
  input  logic              man_rdy,
  input  tcb_pkg::tcb_rsp_t man_rsp,
  input  tcb_pkg::ben_t     man_rbe
);

  // granule width in bits
  localparam int unsigned GRN_W = GRN * tcb_pkg::BYTE_W;

  ////////////////////////////////////////////////////////////
  // request path
  ////////////////////////////////////////////////////////////

  assign man_vld = sub_vld;
  assign man_req = sub_req;
  assign sub_rdy = man_rdy;

  ////////////////////////////////////////////////////////////
  // response path
  ////////////////////////////////////////////////////////////

  always_ff @(posedge man) begin
    if (reset) begin
      sub_rsp <= '0;
    end else begin
      // first byte enable of each granule decides its update
      for (int unsigned i = 0; i < tcb_pkg::BEN_W; i += GRN) begin
        if (man_rbe[i]) begin
          sub_rsp.rdt[i*tcb_pkg::BYTE_W +: GRN_W] <= man_rsp.rdt[i*tcb_pkg::BYTE_W +: GRN_W];
        end
      end
      // status always follows, so an error pulse is not lost
      sub_rsp.sts <= man_rsp.sts;
    end
  end

endmodule

// ==== hdl/tcb_regs.sv ====
// TCB subordinate register block
// scratch and control registers, accepted write counter and a fixed id,
// with an error status for writes to read-only or unmapped offsets

`timescale 1ns/1ns

module tcb_regs (
  input  logic              man,
  input  logic              reset,
  input  logic              vld,
  input  tcb_pkg::tcb_req_t req,
  output logic              rdy,
  output tcb_pkg::tcb_rsp_t rsp
);

  ////////////////////////////////////////////////////////////
  // decode
  ////////////////////////////////////////////////////////////

  tcb_pkg::reg_off_t off;
  logic              trn;
  logic              err;
  logic              wr_ok;

  // register contents
  tcb_pkg::data_t    scratch;
  tcb_pkg::data_t    control;
  tcb_pkg::data_t    wcount;

  // response registers
  tcb_pkg::data_t    rdt_q;
  tcb_pkg::sts_t     sts_q;

  assign off = req.adr[tcb_pkg::SEL_BIT-1:2];
  assign trn = vld && rdy;

  // offsets past ID are unmapped, WCOUNT and ID are read only
  always_comb begin
    err = 1'b0;
    if (off > tcb_pkg::REG_ID) begin
      err = 1'b1;
    end else if (req.wen && (off == tcb_pkg::REG_WCOUNT || off == tcb_pkg::REG_ID)) begin
      err = 1'b1;
    end
  end

  // a write that actually lands in a register
  assign wr_ok = trn && req.wen && !err;

  ////////////////////////////////////////////////////////////
  // handshake
  ////////////////////////////////////////////////////////////

  always_ff @(posedge man) begin
    if (reset) begin
      rdy <= 1'b0;
    end else begin
      rdy <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // register file
  ////////////////////////////////////////////////////////////

  always_ff @(posedge man) begin
    if (reset) begin
      scratch <= '0;
      control <= '0;
      wcount  <= '0;
    end else if (wr_ok) begin
      if (off == tcb_pkg::REG_SCRATCH) begin
        scratch <= tcb_pkg::ben_merge(scratch, req.wdt, req.ben);
      end
      if (off == tcb_pkg::REG_CONTROL) begin
        control <= tcb_pkg::ben_merge(control, req.wdt, req.ben);
      end
      // counts accepted writes only
      wcount <= wcount + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // read path
  ////////////////////////////////////////////////////////////

  // read data only moves on a read, the slice ignores it otherwise
  always_ff @(posedge man) begin
    if (trn && !req.wen) begin
      if (err) begin
        rdt_q <= '0;
      end else begin
        case (off)
          tcb_pkg::REG_SCRATCH: rdt_q <= scratch;
          tcb_pkg::REG_CONTROL: rdt_q <= control;
          tcb_pkg::REG_WCOUNT:  rdt_q <= wcount;
          default:              rdt_q <= tcb_pkg::REG_ID_VALUE;
        endcase
      end
    end
  end

  // error pulse, one cycle per failed transfer
  always_ff @(posedge man) begin
    if (reset) begin
      sts_q <= '0;
    end else begin
      sts_q <= tcb_pkg::sts_t'(trn && err);
    end
  end

  assign rsp.rdt = rdt_q;
  assign rsp.sts = sts_q;

endmodule

// ==== hdl/tcb_sram.sv ====
// TCB subordinate SRAM
// single port word memory with byte-enable writes and a registered read port

`timescale 1ns/1ns

module tcb_sram #(
  // word address width, the memory holds 2**SRAM_AW words
  parameter int unsigned SRAM_AW = 10
)(
  input  logic              man,
  input  logic              reset,
  input  logic              vld,
  input  tcb_pkg::tcb_req_t req,
  output logic              rdy,
  output tcb_pkg::tcb_rsp_t rsp
);

  ////////////////////////////////////////////////////////////
  // local signals
  ////////////////////////////////////////////////////////////

  localparam int unsigned DEPTH = 2**SRAM_AW;

  // word address, byte offset bits dropped
  logic [SRAM_AW-1:0] wadr;

  // transfer strobes
  logic               trn_wr;
  logic               trn_rd;

  // storage, no reset on the array
  tcb_pkg::data_t     mem [DEPTH];

  // read data register
  tcb_pkg::data_t     rdt_q;

  assign wadr   = req.adr[SRAM_AW+1:2];
  assign trn_wr = vld && rdy &&  req.wen;
  assign trn_rd = vld && rdy && !req.wen;

  ////////////////////////////////////////////////////////////
  // handshake
  ////////////////////////////////////////////////////////////

  // never stalls, rdy rises on the first edge out of reset
  always_ff @(posedge man) begin
    if (reset) begin
      rdy <= 1'b0;
    end else begin
      rdy <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // memory array
  ////////////////////////////////////////////////////////////

  // one write lane per byte
  always_ff @(posedge man) begin
    if (trn_wr) begin
      for (int unsigned b = 0; b < tcb_pkg::BEN_W; b++) begin
        if (req.ben[b]) begin
          mem[wadr][b*tcb_pkg::BYTE_W +: tcb_pkg::BYTE_W] <=
            req.wdt[b*tcb_pkg::BYTE_W +: tcb_pkg::BYTE_W];
        end
      end
    end
  end

  // full word is read, byte lanes are picked later by rbe
  always_ff @(posedge man) begin
    if (trn_rd) begin
      rdt_q <= mem[wadr];
    end
  end

  ////////////////////////////////////////////////////////////
  // response
  ////////////////////////////////////////////////////////////

  assign rsp.rdt = rdt_q;
  // memory accesses never fail
  assign rsp.sts = '0;

endmodule

// ==== hdl/tcb_subsystem.sv ====
// TCB subsystem top level
// one manager port, response slice, device select, SRAM and register block

`timescale 1ns/1ns

module tcb_subsystem #(
  // response hold granularity in bytes
  parameter int unsigned GRN     = 1,
  // SRAM word address width
  parameter int unsigned SRAM_AW = 10
)(
  input  logic              man,
  input  logic              reset,
  input  logic              vld,
  input  tcb_pkg::tcb_req_t req,
  output logic              rdy,
  output tcb_pkg::tcb_rsp_t rsp
);

  ////////////////////////////////////////////////////////////
  // internal buses
  ////////////////////////////////////////////////////////////

  // slice to device select
  logic              sel_vld;
  tcb_pkg::tcb_req_t sel_req;
  logic              sel_rdy;
  tcb_pkg::tcb_rsp_t sel_rsp;
  tcb_pkg::ben_t     sel_rbe;

  // device select to sram
  logic              sram_vld;
  tcb_pkg::tcb_req_t sram_req;
  logic              sram_rdy;
  tcb_pkg::tcb_rsp_t sram_rsp;

  // device select to register block
  logic              regs_vld;
  tcb_pkg::tcb_req_t regs_req;
  logic              regs_rdy;
  tcb_pkg::tcb_rsp_t regs_rsp;

  ////////////////////////////////////////////////////////////
  // response slice
  ////////////////////////////////////////////////////////////

  tcb_register_response #(
    .GRN (GRN)
  ) u_rsp_slice (
    .man     (man),
    .reset   (reset),
    .sub_vld (vld),
    .sub_req (req),
    .sub_rdy (rdy),
    .sub_rsp (rsp),
    .man_vld (sel_vld),
    .man_req (sel_req),
    .man_rdy (sel_rdy),
    .man_rsp (sel_rsp),
    .man_rbe (sel_rbe)
  );

  ////////////////////////////////////////////////////////////
  // device select and subordinates
  ////////////////////////////////////////////////////////////

  tcb_dev_select u_dev_select (
    .man        (man),
    .reset      (reset),
    .host_vld   (sel_vld),
    .host_req   (sel_req),
    .host_rdy   (sel_rdy),
    .sram_vld   (sram_vld),
    .sram_req   (sram_req),
    .sram_rdy   (sram_rdy),
    .sram_rsp   (sram_rsp),
    .regs_vld   (regs_vld),
    .regs_req   (regs_req),
    .regs_rdy   (regs_rdy),
    .regs_rsp   (regs_rsp),
    .merged_rsp (sel_rsp),
    .merged_rbe (sel_rbe)
  );

  tcb_sram #(
    .SRAM_AW (SRAM_AW)
  ) u_sram (
    .man   (man),
    .reset (reset),
    .vld   (sram_vld),
    .req   (sram_req),
    .rdy   (sram_rdy),
    .rsp   (sram_rsp)
  );

  tcb_regs u_regs (
    .man   (man),
    .reset (reset),
    .vld   (regs_vld),
    .req   (regs_req),
    .rdy   (regs_rdy),
    .rsp   (regs_rsp)
  );

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the TCB subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tcb_subsystem_tb \
  -f vlog.f \
  -o tcb_sim

# the pass line in the output decides the result
out=$(./obj_dir/tcb_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -q "Everything OK"; then
  exit 0
fi
exit 1

// ==== tb/tcb_subsystem_sva.sv ====
// TCB subsystem port checks
// checks handshake and response timing on the top-level ports of the DUT

`timescale 1ns/1ns

module tcb_subsystem_sva (
  input logic              man,
  input logic              reset,
  input logic              vld,
  input tcb_pkg::tcb_req_t req,
  input logic              rdy,
  input tcb_pkg::tcb_rsp_t rsp
);

  ////////////////////////////////////////////////////////////
  // handshake events
  ////////////////////////////////////////////////////////////

  logic        rd_hs;
  logic        any_hs;
  // number of failed assertions
  int unsigned n_fail = 0;

  // a read transfer is the only event that may move rdt
  assign rd_hs  = vld && rdy && !req.wen;
  // only a transfer may raise sts
  assign any_hs = vld && rdy;

  ////////////////////////////////////////////////////////////
  // properties
  ////////////////////////////////////////////////////////////

  // subordinates never stall once out of reset
  rdy_after_reset: assert property (
    @(posedge man) disable iff (reset)
    !$past(reset) |-> rdy
  ) else begin
    n_fail = n_fail + 1;
    $error("rdy low after reset");
  end

  // slice output cleared by the synchronous reset
  rsp_zero_in_reset: assert property (
    @(posedge man)
    reset |=> (rsp == '0)
  ) else begin
    n_fail = n_fail + 1;
    $error("rsp not zero after a reset cycle");
  end

  // held read data moves only two cycles after a read
  rdt_hold: assert property (
    @(posedge man) disable iff (reset)
    !$past(rd_hs, 2) |-> $stable(rsp.rdt)
  ) else begin
    n_fail = n_fail + 1;
    $error("rsp.rdt changed without a read two cycles earlier");
  end

  // an error pulse needs a transfer two cycles earlier
  sts_idle: assert property (
    @(posedge man) disable iff (reset)
    !$past(any_hs, 2) |-> (rsp.sts == '0)
  ) else begin
    n_fail = n_fail + 1;
    $error("rsp.sts set without a transfer two cycles earlier");
  end

endmodule

// ==== tb/tcb_subsystem_tb.sv ====
// TCB subsystem testbench
// seeded random transfers checked against a model of the SRAM, the
// register block and the response slice

`timescale 1ns/1ns

module tcb_subsystem_tb;

  localparam int unsigned GRN         = 2;
  localparam int unsigned SRAM_AW     = 10;
  // transfers issued by all tests together
  localparam int unsigned N_XFER      = 36;
  localparam int unsigned WATCHDOG_NS = (N_XFER + 50) * 40;

  logic              man;
  logic              reset;
  logic              vld;
  tcb_pkg::tcb_req_t req;
  logic              rdy;
  tcb_pkg::tcb_rsp_t rsp;

  // scoreboard holds one entry per handshake that falls due two cycles later
  int unsigned       due_q  [$];
  tcb_pkg::tcb_rsp_t exp_q  [$];
  string             name_q [$];

  // model of the subordinates and of the held slice data
  tcb_pkg::data_t    sram_mdl [int unsigned];
  tcb_pkg::data_t    scratch_mdl;
  tcb_pkg::data_t    control_mdl;
  tcb_pkg::data_t    wcount_mdl;
  tcb_pkg::data_t    held_rdt;

  int unsigned       cyc;
  int unsigned       n_checks;
  int unsigned       n_errors;
  int unsigned       chk_mark;
  int unsigned       err_mark;
  logic              hs_done;
  string             test_name;
  tcb_pkg::adr_t     sram_adrs [$];

  tcb_subsystem #(
    .GRN     (GRN),
    .SRAM_AW (SRAM_AW)
  ) DUT (
    .man   (man),
    .reset (reset),
    .vld   (vld),
    .req   (req),
    .rdy   (rdy),
    .rsp   (rsp)
  );

  bind tcb_subsystem tcb_subsystem_sva u_sva (
    .man   (man),
    .reset (reset),
    .vld   (vld),
    .req   (req),
    .rdy   (rdy),
    .rsp   (rsp)
  );

  always #20 man = ~man;

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  // takes enabled byte lanes from new_dat and the rest from old_dat
  function automatic tcb_pkg::data_t merge_bytes(tcb_pkg::data_t old_dat,
                                                 tcb_pkg::data_t new_dat,
                                                 tcb_pkg::ben_t  ben);
    tcb_pkg::data_t res;
    for (int b = 0; b < 4; b++) begin
      res[8*b +: 8] = ben[b] ? new_dat[8*b +: 8] : old_dat[8*b +: 8];
    end
    return res;
  endfunction

  // a granule follows the read data when its lowest byte is enabled
  function automatic tcb_pkg::data_t hold_granules(tcb_pkg::data_t held,
                                                   tcb_pkg::data_t dat,
                                                   tcb_pkg::ben_t  ben);
    tcb_pkg::data_t res;
    res = held;
    for (int b = 0; b < 4; b++) begin
      if (ben[b - (b % GRN)]) begin
        res[8*b +: 8] = dat[8*b +: 8];
      end
    end
    return res;
  endfunction

  // applies one transfer to the model and returns the expected response
  function automatic tcb_pkg::tcb_rsp_t predict(tcb_pkg::tcb_req_t r);
    tcb_pkg::tcb_rsp_t e;
    tcb_pkg::data_t    dat;
    int unsigned       key;
    int unsigned       off;
    logic              err;
    dat = '0;
    err = 1'b0;
    if (!r.adr[tcb_pkg::SEL_BIT]) begin
      key = 32'(r.adr[SRAM_AW+1:2]);
      if (r.wen) begin
        sram_mdl[key] = merge_bytes(sram_mdl.exists(key) ? sram_mdl[key] : 'x, r.wdt, r.ben);
      end else begin
        dat = sram_mdl[key];
      end
    end else begin
      off = 32'(r.adr[tcb_pkg::SEL_BIT-1:2]);
      // wcount and id are read only and nothing is mapped past id
      err = (off > 3) || (r.wen && off >= 2);
      if (!err && r.wen) begin
        if (off == 0) begin
          scratch_mdl = merge_bytes(scratch_mdl, r.wdt, r.ben);
        end else begin
          control_mdl = merge_bytes(control_mdl, r.wdt, r.ben);
        end
        wcount_mdl = wcount_mdl + 1;
      end else if (!err) begin
        case (off)
          0:       dat = scratch_mdl;
          1:       dat = control_mdl;
          2:       dat = wcount_mdl;
          default: dat = tcb_pkg::REG_ID_VALUE;
        endcase
      end
    end
    // writes leave the held data alone
    if (!r.wen) begin
      held_rdt = hold_granules(held_rdt, dat, r.ben);
    end
    e.rdt = held_rdt;
    e.sts = err;
    return e;
  endfunction

  ////////////////////////////////////////////////////////////
  // monitor and checker
  ////////////////////////////////////////////////////////////

  task automatic expect_eq(input string what, input logic [63:0] exp, input logic [63:0] act);
    n_checks = n_checks + 1;
    assert (act === exp) else begin
      $display("[FAIL] %s: expected %h, actual %h", what, exp, act);
      n_errors = n_errors + 1;
    end
  endtask

  // handshakes are taken on the rising edge
  always @(posedge man) begin
    if (vld && rdy) begin
      due_q.push_back(cyc + 2);
      exp_q.push_back(predict(req));
      name_q.push_back(test_name);
      hs_done = 1'b1;
    end
    cyc = cyc + 1;
  end

  // response checked in the low phase after its second edge
  always @(negedge man) begin
    if (due_q.size() != 0 && due_q[0] == cyc) begin
      expect_eq({name_q[0], " rdt"}, exp_q[0].rdt, rsp.rdt);
      expect_eq({name_q[0], " sts"}, exp_q[0].sts, rsp.sts);
      void'(due_q.pop_front());
      void'(exp_q.pop_front());
      void'(name_q.pop_front());
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////

  // starts on a falling edge and returns on the falling edge after the handshake
  task automatic xfer(input logic wen, input tcb_pkg::adr_t adr,
                      input tcb_pkg::ben_t ben, input tcb_pkg::data_t wdt);
    hs_done = 1'b0;
    vld     = 1'b1;
    req.wen = wen;
    req.adr = adr;
    req.ben = ben;
    req.wdt = wdt;
    do begin
      @(negedge man);
    end while (!hs_done);
  endtask

  function automatic tcb_pkg::adr_t rand_sram_adr();
    tcb_pkg::adr_t a;
    a = '0;
    a[SRAM_AW+1:2] = SRAM_AW'($urandom());
    return a;
  endfunction

  function automatic tcb_pkg::adr_t reg_adr(input int unsigned off);
    tcb_pkg::adr_t a;
    a = '0;
    a[tcb_pkg::SEL_BIT] = 1'b1;
    a[tcb_pkg::SEL_BIT-1:2] = tcb_pkg::reg_off_t'(off);
    return a;
  endfunction

  task automatic start_test(input string name);
    test_name = name;
    chk_mark  = n_checks;
    err_mark  = n_errors;
  endtask

  // idle the bus until every response of the test was checked
  task automatic finish_test();
    vld = 1'b0;
    while (due_q.size() != 0) begin
      @(posedge man);
    end
    @(negedge man);
    $display("test %-14s checks %0d, errors %0d", test_name,
             n_checks - chk_mark, n_errors - err_mark);
  endtask

  ////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////

  initial begin
    tcb_pkg::adr_t a;
    tcb_pkg::adr_t b;
    int unsigned   sva_fails;
    man         = 1'b0;
    reset       = 1'b1;
    vld         = 1'b0;
    req         = '0;
    cyc         = 0;
    n_checks    = 0;
    n_errors    = 0;
    hs_done     = 1'b0;
    test_name   = "reset";
    scratch_mdl = '0;
    control_mdl = '0;
    wcount_mdl  = '0;
    held_rdt    = '0;
    void'($urandom(32'h606a));
    repeat (10) @(negedge man);
    reset = 1'b0;

    // idle bus after reset and then a write that must not move rsp
    start_test("reset_idle");
    repeat (3) begin
      @(negedge man);
      expect_eq("reset_idle rdy", 1, rdy);
      expect_eq("reset_idle rsp", 0, rsp);
    end
    xfer(1'b1, rand_sram_adr(), 4'hf, $urandom());
    finish_test();

    // full words written and read back in the same order
    start_test("sram_word");
    repeat (4) begin
      a = rand_sram_adr();
      sram_adrs.push_back(a);
      xfer(1'b1, a, 4'hf, $urandom());
    end
    foreach (sram_adrs[i]) begin
      xfer(1'b0, sram_adrs[i], 4'hf, '0);
    end
    finish_test();

    // byte merge on write and granule hold on partial reads
    start_test("sram_partial");
    a = rand_sram_adr();
    b = a ^ 16'h0004;
    xfer(1'b1, a, 4'hf, $urandom());
    xfer(1'b1, b, 4'hf, $urandom());
    xfer(1'b1, a, 4'b0101, $urandom());
    xfer(1'b0, b, 4'hf, '0);
    xfer(1'b0, a, 4'b1100, '0);
    xfer(1'b0, a, 4'b0011, '0);
    finish_test();

    // scratch, control, id and the write count
    start_test("regs_rw");
    xfer(1'b1, reg_adr(0), 4'hf, $urandom());
    xfer(1'b1, reg_adr(1), 4'hf, $urandom());
    xfer(1'b1, reg_adr(1), 4'b0110, $urandom());
    xfer(1'b0, reg_adr(0), 4'hf, '0);
    xfer(1'b0, reg_adr(1), 4'hf, '0);
    xfer(1'b0, reg_adr(3), 4'hf, '0);
    xfer(1'b0, reg_adr(2), 4'hf, '0);
    finish_test();

    // read-only and unmapped offsets followed by reads showing nothing moved
    start_test("regs_error");
    xfer(1'b1, reg_adr(3), 4'hf, $urandom());
    xfer(1'b1, reg_adr(2), 4'hf, $urandom());
    xfer(1'b0, reg_adr(5), 4'hf, '0);
    xfer(1'b1, reg_adr(6), 4'hf, $urandom());
    xfer(1'b0, reg_adr(0), 4'hf, '0);
    xfer(1'b0, reg_adr(2), 4'hf, '0);
    finish_test();

    // sram and register reads on consecutive cycles
    start_test("alternate");
    for (int i = 0; i < 4; i++) begin
      xfer(1'b0, sram_adrs[i], 4'hf, '0);
      xfer(1'b0, reg_adr(i), 4'hf, '0);
    end
    finish_test();

    // bound port assertions count toward the result as well
    sva_fails = DUT.u_sva.n_fail;
    $display("tests 6, checks %0d, errors %0d, assertion failures %0d",
             n_checks, n_errors, sva_fails);
    if (n_errors == 0 && sva_fails == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // watchdog sized from the transfer count
  initial begin
    #(WATCHDOG_NS);
    $display("timeout after %0d ns, the tests did not complete", WATCHDOG_NS);
    $display("Something failed");
    $finish;
  end

endmodule

// ==== vlog.f ====
// packages first, then the RTL from the leaves up
hdl/tcb_pkg.sv
hdl/tcb_sram.sv
hdl/tcb_regs.sv
hdl/tcb_dev_select.sv
hdl/tcb_register_response.sv
hdl/tcb_subsystem.sv
// testbench and bound assertions
tb/tcb_subsystem_sva.sv
tb/tcb_subsystem_tb.sv
